//--- design/fpgaRegPkg.sv
/*
 * Shared definitions for the register access subsystem.
 * Holds bus widths, register indices, reset values, counter widths and
 * the structs passed between blocks. Design files refer to it by scoped name.
 */
package fpgaRegPkg;

	// Register bus
	localparam int REGA_BITS = 14;
	localparam int REGD_BITS = 32;
	localparam int FLAG_BITS = 6;

	// Ring, peripheral, board-to-board 1, board-to-board 0
	localparam int NUM_LINKS = 4;

	// Register map
	localparam logic [REGA_BITS-1:0] VERS_REG = 14'd0;
	localparam logic [REGA_BITS-1:0] FLAG_REG = 14'd1;
	localparam logic [REGA_BITS-1:0] PKEY_REG = 14'd2;
	localparam logic [REGA_BITS-1:0] PMSK_REG = 14'd3;
	localparam logic [REGA_BITS-1:0] SCRM_REG = 14'd4;
	localparam logic [REGA_BITS-1:0] SLEN_REG = 14'd5;
	localparam logic [REGA_BITS-1:0] LEDO_REG = 14'd6;
	localparam logic [REGA_BITS-1:0] RXEQ_REG = 14'd7;
	localparam logic [REGA_BITS-1:0] TXDS_REG = 14'd8;
	localparam logic [REGA_BITS-1:0] TXPE_REG = 14'd9;

	// Transceiver fields, four links packed ring first
	localparam int RXEQ_BITS = 8;
	localparam int TXDS_BITS = 16;
	localparam int TXPE_BITS = 12;

	// Per-link analog values, board-to-board tuned, others left default
	localparam logic [1:0] B2B_RXEQMIX = 2'b10;
	localparam logic [1:0] DEF_RXEQMIX = 2'b00;
	localparam logic [3:0] B2B_TXDIFFCTRL = 4'b0110;
	localparam logic [3:0] DEF_TXDIFFCTRL = 4'b0000;
	localparam logic [2:0] B2B_TXPREEMPH = 3'b010;
	localparam logic [2:0] DEF_TXPREEMPH = 3'b000;

	// Short counters suit simulation; widen for visible blink on a board
	localparam int BLINK_BITS = 4;
	localparam int PWM_BITS = 3;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

	typedef struct packed {
		logic write;
		logic [REGA_BITS-1:0] addr;
		logic [REGD_BITS-1:0] data;
	} regRequest;

	// Upper nibble dims, lower nibble forces error blink
	typedef struct packed {
		logic [NUM_LINKS-1:0] dim;
		logic [NUM_LINKS-1:0] forceErr;
	} ledOverride;

	typedef struct packed {
		logic [RXEQ_BITS-1:0] rxEqMix;
		logic [TXDS_BITS-1:0] txDiffCtrl;
		logic [TXPE_BITS-1:0] txPreEmphasis;
	} gtpSettings;

	// Reset values
	localparam logic [REGD_BITS-1:0] PKEY_RESET = '1;
	localparam logic [REGD_BITS-1:0] PMSK_RESET = '0;
	localparam logic [REGD_BITS-1:0] SCRM_RESET = '1;
	localparam logic [REGD_BITS-1:0] SLEN_RESET = '0;
	localparam ledOverride LEDO_RESET = 8'h0F;
	localparam gtpSettings GTP_RESET = '{
		rxEqMix: {DEF_RXEQMIX, DEF_RXEQMIX, B2B_RXEQMIX, B2B_RXEQMIX},
		txDiffCtrl: {DEF_TXDIFFCTRL, DEF_TXDIFFCTRL, B2B_TXDIFFCTRL, B2B_TXDIFFCTRL},
		txPreEmphasis: {DEF_TXPREEMPH, DEF_TXPREEMPH, B2B_TXPREEMPH, B2B_TXPREEMPH}
	};

endpackage

//--- design/cmdFifo.sv
/*
 * Small synchronous FIFO with show-ahead output.
 * The payload type is a parameter so one block serves requests and replies.
 */
module cmdFifo
#(
	parameter type payloadType = logic [fpgaRegPkg::REGD_BITS-1:0]
)
(
	input logic CLK_IN,
	input logic RESET_IN,
	input logic push,
	input payloadType pushData,
	input logic pop,
	output payloadType popData,
	output logic empty,
	output logic full
);

	payloadType mem [fpgaRegPkg::FIFO_DEPTH];
	logic [fpgaRegPkg::FIFO_PTR_BITS-1:0] wrPtr;
	logic [fpgaRegPkg::FIFO_PTR_BITS-1:0] rdPtr;
	logic [fpgaRegPkg::FIFO_PTR_BITS:0] count;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign empty = (count == 0);
	assign full = (count == fpgaRegPkg::FIFO_DEPTH);

	always_ff @(posedge CLK_IN, posedge RESET_IN)
		if (RESET_IN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == fpgaRegPkg::FIFO_DEPTH - 1) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == fpgaRegPkg::FIFO_DEPTH - 1) ? '0 : rdPtr + 1'b1;
			// Simultaneous push and pop leaves occupancy unchanged
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end

	always_ff @(posedge CLK_IN)
		if (doPush)
			mem[wrPtr] <= pushData;

	// Head entry visible before the pop
	assign popData = mem[rdPtr];

	// No back-pressure, so the neighbours must respect capacity
	noOverflow: assert property (@(posedge CLK_IN) disable iff (RESET_IN) push |-> !full)
		else $error("cmdFifo push while full");
	noUnderflow: assert property (@(posedge CLK_IN) disable iff (RESET_IN) pop |-> !empty)
		else $error("cmdFifo pop while empty");

endmodule

//--- design/cmdFrontEnd.sv
/*
 * Host byte stream front end.
 * Gathers command bytes into register requests for the request FIFO and
 * streams read replies back as four bytes, most significant first.
 */
module cmdFrontEnd
(
	input logic CLK_IN,
	input logic RESET_IN,
	// Host receive strobe
	input logic rxValid,
	input logic [7:0] rxByte,
	// Request FIFO side
	output logic reqPush,
	output fpgaRegPkg::regRequest reqData,
	// Reply FIFO side
	input logic replyEmpty,
	output logic replyPop,
	input logic [fpgaRegPkg::REGD_BITS-1:0] replyData,
	// Host transmit strobe
	output logic txValid,
	output logic [7:0] txByte
);

	// Byte index 0 to 5 within the current command
	logic [2:0] rxCount;
	logic rxLast;

	// Transmit shifter
	logic txBusy;
	logic [1:0] txCount;
	logic txDone;
	logic [fpgaRegPkg::REGD_BITS-1:0] txShift;

	// Read ends after header, write after four data bytes
	assign rxLast = rxValid && ((rxCount == 3'd1 && !reqData.write) || rxCount == 3'd5);

	always_ff @(posedge CLK_IN, posedge RESET_IN)
		if (RESET_IN)
		begin
			rxCount <= '0;
			reqPush <= 1'b0;
		end
		else
		begin
			// Push lands one cycle after the closing byte
			reqPush <= rxLast;
			if (rxValid)
				rxCount <= rxLast ? 3'd0 : rxCount + 3'd1;
		end

	// Big-endian command fields
	always_ff @(posedge CLK_IN)
		if (rxValid)
		begin
			case (rxCount)
				3'd0:
				begin
					// Bit 7 is the write flag and bit 6 is unused
					reqData.write <= rxByte[7];
					reqData.addr[fpgaRegPkg::REGA_BITS-1:8] <= rxByte[fpgaRegPkg::REGA_BITS-9:0];
				end
				3'd1:
					reqData.addr[7:0] <= rxByte;
				default:
					reqData.data <= {reqData.data[fpgaRegPkg::REGD_BITS-9:0], rxByte};
			endcase
		end

	// Last byte of current reply going out
	assign txDone = txBusy && (txCount == 2'd3);

	// Take next reply on the final byte so replies run back to back
	assign replyPop = (!txBusy || txDone) && !replyEmpty;

	always_ff @(posedge CLK_IN, posedge RESET_IN)
		if (RESET_IN)
		begin
			txBusy <= 1'b0;
			txCount <= '0;
		end
		else if (replyPop)
		begin
			txBusy <= 1'b1;
			txCount <= '0;
		end
		else if (txBusy)
		begin
			txCount <= txCount + 2'd1;
			if (txDone)
				txBusy <= 1'b0;
		end

	always_ff @(posedge CLK_IN)
		if (replyPop)
			txShift <= replyData;
		else if (txBusy)
			txShift <= txShift << 8;

	assign txValid = txBusy;
	assign txByte = txShift[fpgaRegPkg::REGD_BITS-1:fpgaRegPkg::REGD_BITS-8];

	// Host must present a defined byte with every strobe
	rxByteKnown: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		rxValid |-> !$isunknown(rxByte))
		else $error("cmdFrontEnd received an undefined byte");

endmodule

//--- design/regSequencer.sv
/*
 * Applies queued register requests to the register bank, one per cycle.
 * Read data is captured a cycle later and pushed into the reply FIFO.
 */
module regSequencer
(
	input logic CLK_IN,
	input logic RESET_IN,
	// Request FIFO
	input logic reqEmpty,
	output logic reqPop,
	input fpgaRegPkg::regRequest reqData,
	// Register bank bus
	output logic regWrite,
	output logic [fpgaRegPkg::REGA_BITS-1:0] regAddr,
	output logic [fpgaRegPkg::REGD_BITS-1:0] regWriteData,
	input logic [fpgaRegPkg::REGD_BITS-1:0] regReadData,
	// Reply FIFO
	output logic replyPush,
	output logic [fpgaRegPkg::REGD_BITS-1:0] replyData
);

	logic readCycle;

	// Head request goes straight onto the bus in the pop cycle
	assign reqPop = !reqEmpty;
	assign regWrite = reqPop && reqData.write;
	assign regAddr = reqData.addr;
	assign regWriteData = reqData.data;
	assign readCycle = reqPop && !reqData.write;

	always_ff @(posedge CLK_IN, posedge RESET_IN)
		if (RESET_IN)
			replyPush <= 1'b0;
		else
			replyPush <= readCycle;

	// Bank read decode is combinational, sample at end of bus cycle
	always_ff @(posedge CLK_IN)
		if (readCycle)
			replyData <= regReadData;

endmodule

//--- design/regBank.sv
/*
 * Control and diagnostic registers of the FPGA.
 * Single-cycle write on a decoded address, combinational read decode.
 * Version and flags are read-only inputs; unmapped reads return all ones.
 */
module regBank
(
	input logic CLK_IN,
	input logic RESET_IN,
	// Register bus
	input logic regWrite,
	input logic [fpgaRegPkg::REGA_BITS-1:0] regAddr,
	input logic [fpgaRegPkg::REGD_BITS-1:0] regWriteData,
	output logic [fpgaRegPkg::REGD_BITS-1:0] regReadData,
	// Build identification
	input logic [fpgaRegPkg::REGD_BITS-1:0] version,
	// Chipscope, periph, ring, north/south on front, FPGA ID[1:0]
	input logic [fpgaRegPkg::FLAG_BITS-1:0] flags,
	// Chip link enables
	output logic [fpgaRegPkg::REGD_BITS-1:0] linkEnable,
	// Peripheral multicast route match
	output logic [fpgaRegPkg::REGD_BITS-1:0] periphMcKey,
	output logic [fpgaRegPkg::REGD_BITS-1:0] periphMcMask,
	// Idle pattern scrambling
	output logic [fpgaRegPkg::REGD_BITS-1:0] scrambleIdle,
	output fpgaRegPkg::ledOverride ledCtrl,
	output fpgaRegPkg::gtpSettings gtp
);

	always_ff @(posedge CLK_IN, posedge RESET_IN)
		if (RESET_IN)
		begin
			periphMcKey <= fpgaRegPkg::PKEY_RESET;
			periphMcMask <= fpgaRegPkg::PMSK_RESET;
			scrambleIdle <= fpgaRegPkg::SCRM_RESET;
			linkEnable <= fpgaRegPkg::SLEN_RESET;
			ledCtrl <= fpgaRegPkg::LEDO_RESET;
			gtp <= fpgaRegPkg::GTP_RESET;
		end
		else if (regWrite)
		begin
			// Version and flags ignore writes
			case (regAddr)
				fpgaRegPkg::PKEY_REG: periphMcKey <= regWriteData;
				fpgaRegPkg::PMSK_REG: periphMcMask <= regWriteData;
				fpgaRegPkg::SCRM_REG: scrambleIdle <= regWriteData;
				fpgaRegPkg::SLEN_REG: linkEnable <= regWriteData;
				fpgaRegPkg::LEDO_REG:
					ledCtrl <= regWriteData[2*fpgaRegPkg::NUM_LINKS-1:0];
				fpgaRegPkg::RXEQ_REG:
					gtp.rxEqMix <= regWriteData[fpgaRegPkg::RXEQ_BITS-1:0];
				fpgaRegPkg::TXDS_REG:
					gtp.txDiffCtrl <= regWriteData[fpgaRegPkg::TXDS_BITS-1:0];
				fpgaRegPkg::TXPE_REG:
					gtp.txPreEmphasis <= regWriteData[fpgaRegPkg::TXPE_BITS-1:0];
				default: ;
			endcase
		end

	// Narrow registers read back zero-extended
	always_comb
		case (regAddr)
			fpgaRegPkg::VERS_REG: regReadData = version;
			fpgaRegPkg::FLAG_REG:
				regReadData = {{(fpgaRegPkg::REGD_BITS-fpgaRegPkg::FLAG_BITS){1'b0}}, flags};
			fpgaRegPkg::PKEY_REG: regReadData = periphMcKey;
			fpgaRegPkg::PMSK_REG: regReadData = periphMcMask;
			fpgaRegPkg::SCRM_REG: regReadData = scrambleIdle;
			fpgaRegPkg::SLEN_REG: regReadData = linkEnable;
			fpgaRegPkg::LEDO_REG:
				regReadData = {{(fpgaRegPkg::REGD_BITS-2*fpgaRegPkg::NUM_LINKS){1'b0}}, ledCtrl};
			fpgaRegPkg::RXEQ_REG:
				regReadData = {{(fpgaRegPkg::REGD_BITS-fpgaRegPkg::RXEQ_BITS){1'b0}},
					gtp.rxEqMix};
			fpgaRegPkg::TXDS_REG:
				regReadData = {{(fpgaRegPkg::REGD_BITS-fpgaRegPkg::TXDS_BITS){1'b0}},
					gtp.txDiffCtrl};
			fpgaRegPkg::TXPE_REG:
				regReadData = {{(fpgaRegPkg::REGD_BITS-fpgaRegPkg::TXPE_BITS){1'b0}},
					gtp.txPreEmphasis};
			// Unmapped
			default: regReadData = '1;
		endcase

endmodule

//--- design/ledDriver.sv
/*
 * Status LED driver.
 * Each LED follows its link state unless the override register forces an
 * error blink or dims it to a low-duty pulse.
 */
module ledDriver
(
	input logic CLK_IN,
	input logic RESET_IN,
	input fpgaRegPkg::ledOverride ledCtrl,
	// Link up per LED, ring first
	input logic [fpgaRegPkg::NUM_LINKS-1:0] linkUp,
	output logic [fpgaRegPkg::NUM_LINKS-1:0] ledOut
);

	logic [fpgaRegPkg::BLINK_BITS-1:0] blinkCount;
	logic blinkPhase;
	logic [fpgaRegPkg::PWM_BITS-1:0] pwmCount;
	logic pwmOn;

	// Free-running, shared by all LEDs
	always_ff @(posedge CLK_IN, posedge RESET_IN)
		if (RESET_IN)
		begin
			blinkCount <= '0;
			blinkPhase <= 1'b0;
			pwmCount <= '0;
		end
		else
		begin
			blinkCount <= blinkCount + 1'b1;
			pwmCount <= pwmCount + 1'b1;
			// Toggle once per blink counter wrap
			if (&blinkCount)
				blinkPhase <= !blinkPhase;
		end

	// One lit cycle per PWM period
	assign pwmOn = (pwmCount == '0);

	// Forced error wins over dim
	always_comb
		for (int i = 0; i < fpgaRegPkg::NUM_LINKS; i++)
		begin
			if (ledCtrl.forceErr[i])
				ledOut[i] = blinkPhase;
			else if (ledCtrl.dim[i])
				ledOut[i] = linkUp[i] && pwmOn;
			else
				ledOut[i] = linkUp[i];
		end

endmodule

//--- design/regAccessTop.sv
/*
 * Register access subsystem top level.
 * Host bytes feed the front end, requests queue to the sequencer and the
 * register bank, read data returns through the reply FIFO.
 */
module regAccessTop
(
	input logic CLK_IN,
	input logic RESET_IN,
	input logic rxValid,
	input logic [7:0] rxByte,
	output logic txValid,
	output logic [7:0] txByte,
	input logic [fpgaRegPkg::REGD_BITS-1:0] version,
	input logic [fpgaRegPkg::FLAG_BITS-1:0] flags,
	input logic [fpgaRegPkg::NUM_LINKS-1:0] linkUp,
	output logic [fpgaRegPkg::REGD_BITS-1:0] linkEnable,
	output logic [fpgaRegPkg::REGD_BITS-1:0] periphMcKey,
	output logic [fpgaRegPkg::REGD_BITS-1:0] periphMcMask,
	output logic [fpgaRegPkg::REGD_BITS-1:0] scrambleIdle,
	output fpgaRegPkg::gtpSettings gtp,
	output logic [fpgaRegPkg::NUM_LINKS-1:0] ledOut
);

	// Front end to request FIFO
	logic reqPush;
	fpgaRegPkg::regRequest reqIn;
	// Request FIFO to sequencer
	logic reqEmpty;
	logic reqPop;
	fpgaRegPkg::regRequest reqOut;
	// Register bus
	logic regWrite;
	logic [fpgaRegPkg::REGA_BITS-1:0] regAddr;
	logic [fpgaRegPkg::REGD_BITS-1:0] regWriteData;
	logic [fpgaRegPkg::REGD_BITS-1:0] regReadData;
	// Sequencer to reply FIFO to front end
	logic replyPush;
	logic [fpgaRegPkg::REGD_BITS-1:0] replyIn;
	logic replyEmpty;
	logic replyPop;
	logic [fpgaRegPkg::REGD_BITS-1:0] replyOut;
	fpgaRegPkg::ledOverride ledCtrl;

	cmdFrontEnd frontEnd_i (.CLK_IN, .RESET_IN, .rxValid, .rxByte, .reqPush,
		.reqData(reqIn), .replyEmpty, .replyPop, .replyData(replyOut), .txValid, .txByte);

	cmdFifo #(.payloadType(fpgaRegPkg::regRequest)) reqFifo_i (.CLK_IN, .RESET_IN,
		.push(reqPush), .pushData(reqIn), .pop(reqPop), .popData(reqOut),
		.empty(reqEmpty), .full());

	regSequencer sequencer_i (.CLK_IN, .RESET_IN, .reqEmpty, .reqPop, .reqData(reqOut),
		.regWrite, .regAddr, .regWriteData, .regReadData, .replyPush, .replyData(replyIn));

	cmdFifo #(.payloadType(logic [fpgaRegPkg::REGD_BITS-1:0])) replyFifo_i (.CLK_IN,
		.RESET_IN, .push(replyPush), .pushData(replyIn), .pop(replyPop), .popData(replyOut),
		.empty(replyEmpty), .full());

	regBank bank_i (.CLK_IN, .RESET_IN, .regWrite, .regAddr, .regWriteData, .regReadData,
		.version, .flags, .linkEnable, .periphMcKey, .periphMcMask, .scrambleIdle,
		.ledCtrl, .gtp);

	ledDriver led_i (.CLK_IN, .RESET_IN, .ledCtrl, .linkUp, .ledOut);

endmodule

//--- testbench/regAccessTb.sv
/*
 * Testbench for the register access subsystem.
 * Sends byte-level read and write commands, checks read replies, register
 * outputs and LED behaviour, and ends with an error count and a verdict.
 */
module regAccessTb;

	logic CLK_IN;
	logic RESET_IN;
	logic rxValid;
	logic [7:0] rxByte;
	logic txValid;
	logic [7:0] txByte;
	logic [31:0] version;
	logic [5:0] flags;
	logic [3:0] linkUp;
	logic [31:0] linkEnable;
	logic [31:0] periphMcKey;
	logic [31:0] periphMcMask;
	logic [31:0] scrambleIdle;
	fpgaRegPkg::gtpSettings gtp;
	logic [3:0] ledOut;

	// Expected contents of the writable registers by index
	logic [31:0] shadow [10];
	// Reply words assembled from txByte
	logic [31:0] replyQueue [$];
	logic [31:0] replyWord;
	logic [1:0] replyBytes;
	// Set while the LED override is known to be clear
	logic followCheck;
	int checkCount;
	int errorCount;

	regAccessTop regAccessTop_i (.CLK_IN, .RESET_IN, .rxValid, .rxByte, .txValid, .txByte,
		.version, .flags, .linkUp, .linkEnable, .periphMcKey, .periphMcMask, .scrambleIdle,
		.gtp, .ledOut);

	always #5 CLK_IN = ~CLK_IN;

	// Collects reply bytes into words MSB first
	always @(posedge CLK_IN)
		if (RESET_IN)
			replyBytes <= 2'd0;
		else if (txValid)
		begin
			if (replyBytes == 2'd3)
				replyQueue.push_back({replyWord[23:0], txByte});
			replyWord <= {replyWord[23:0], txByte};
			replyBytes <= replyBytes + 2'd1;
		end

	quietInReset: assert property (@(posedge CLK_IN) RESET_IN |-> !txValid)
		else
		begin
			$display("txValid was active during reset");
			errorCount++;
		end

	ledFollowsLink: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		followCheck |-> ledOut == linkUp)
		else
		begin
			$display("CHECK FAILED led follow expected %h actual %h", linkUp, ledOut);
			errorCount++;
		end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		valueMatch: assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic waitCycles(input int n);
		repeat (n)
		begin
			@(posedge CLK_IN);
			#1;
		end
	endtask

	// Drives one strobe starting a step after a rising edge
	task automatic sendByte(input logic [7:0] value);
		rxValid = 1'b1;
		rxByte = value;
		@(posedge CLK_IN);
		#1;
		rxValid = 1'b0;
	endtask

	task automatic sendReadHeader(input int idx);
		sendByte({2'b00, idx[13:8]});
		sendByte(idx[7:0]);
	endtask

	task automatic writeReg(input int idx, input logic [31:0] data);
		sendByte({2'b10, idx[13:8]});
		sendByte(idx[7:0]);
		sendByte(data[31:24]);
		sendByte(data[23:16]);
		sendByte(data[15:8]);
		sendByte(data[7:0]);
	endtask

	task automatic awaitReply(input string name, output logic [31:0] data);
		int waited;
		waited = 0;
		while (replyQueue.size() == 0 && waited < 64)
		begin
			@(posedge CLK_IN);
			#1;
			waited++;
		end
		if (replyQueue.size() == 0)
		begin
			$display("no reply for %s within 64 cycles", name);
			errorCount++;
			data = 'x;
		end
		else
			data = replyQueue.pop_front();
	endtask

	task automatic readAndCheck(input string name, input int idx);
		logic [31:0] data;
		sendReadHeader(idx);
		awaitReply(name, data);
		checkValue(name, expectedRead(idx), data);
	endtask

	// Field widths of the narrow registers
	function automatic logic [31:0] widthMask(input int idx);
		case (idx)
			6, 7: return 32'h0000_00ff;
			8: return 32'h0000_ffff;
			9: return 32'h0000_0fff;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	function automatic logic [31:0] expectedRead(input int idx);
		if (idx == 0)
			return version;
		else if (idx == 1)
			return {26'd0, flags};
		else if (idx <= 9)
			return shadow[idx];
		return 32'hffff_ffff;
	endfunction

	// Zero-extended top-level output driven by a register
	function automatic logic [31:0] observedOutput(input int idx);
		case (idx)
			2: return periphMcKey;
			3: return periphMcMask;
			4: return scrambleIdle;
			5: return linkEnable;
			7: return {24'd0, gtp.rxEqMix};
			8: return {16'd0, gtp.txDiffCtrl};
			default: return {20'd0, gtp.txPreEmphasis};
		endcase
	endfunction

	initial
	begin
		logic [31:0] seedWord;
		logic [31:0] data;
		logic firstLed;
		int waited;
		int litCount;
		int burstIdx [4];
		void'($urandom(32'hce5e));
		CLK_IN = 1'b0;
		RESET_IN = 1'b1;
		rxValid = 1'b0;
		rxByte = 8'd0;
		linkUp = 4'd0;
		followCheck = 1'b0;
		checkCount = 0;
		errorCount = 0;
		version = $urandom();
		seedWord = $urandom();
		flags = seedWord[5:0];
		// Reset values with board-to-board links on the two low lanes
		shadow[2] = 32'hffff_ffff;
		shadow[3] = 32'd0;
		shadow[4] = 32'hffff_ffff;
		shadow[5] = 32'd0;
		shadow[6] = 32'h0000_000f;
		shadow[7] = {24'd0, fpgaRegPkg::DEF_RXEQMIX, fpgaRegPkg::DEF_RXEQMIX,
			fpgaRegPkg::B2B_RXEQMIX, fpgaRegPkg::B2B_RXEQMIX};
		shadow[8] = {16'd0, fpgaRegPkg::DEF_TXDIFFCTRL, fpgaRegPkg::DEF_TXDIFFCTRL,
			fpgaRegPkg::B2B_TXDIFFCTRL, fpgaRegPkg::B2B_TXDIFFCTRL};
		shadow[9] = {20'd0, fpgaRegPkg::DEF_TXPREEMPH, fpgaRegPkg::DEF_TXPREEMPH,
			fpgaRegPkg::B2B_TXPREEMPH, fpgaRegPkg::B2B_TXPREEMPH};
		repeat (8) @(posedge CLK_IN);
		#1;
		RESET_IN = 1'b0;
		waitCycles(2);

		for (int i = 2; i <= 9; i++)
			readAndCheck($sformatf("reset value %0d", i), i);
		readAndCheck("version", 0);
		readAndCheck("flags", 1);

		// Write lands in the bank 3 cycles after the last byte
		for (int i = 2; i <= 9; i++)
		begin
			data = $urandom();
			writeReg(i, data);
			// Old value still holds one cycle before the bank write edge
			waitCycles(1);
			if (i != 6)
				checkValue($sformatf("output of %0d before write", i), shadow[i],
					observedOutput(i));
			shadow[i] = data & widthMask(i);
			waitCycles(1);
			if (i != 6)
				checkValue($sformatf("output of %0d", i), shadow[i], observedOutput(i));
			readAndCheck($sformatf("readback %0d", i), i);
		end
		writeReg(0, $urandom());
		writeReg(1, $urandom());
		readAndCheck("version after write", 0);
		readAndCheck("flags after write", 1);
		readAndCheck("unmapped 10", 10);
		readAndCheck("unmapped 3fff", 14'h3fff);

		// With the override clear the LEDs track random link states
		writeReg(6, 32'h00);
		shadow[6] = 32'h00;
		waitCycles(2);
		followCheck = 1'b1;
		repeat (24)
		begin
			seedWord = $urandom();
			linkUp = seedWord[3:0];
			waitCycles(1);
		end
		followCheck = 1'b0;

		// Forced error on LED 0 must toggle
		linkUp = 4'b0000;
		writeReg(6, 32'h01);
		shadow[6] = 32'h01;
		waitCycles(2);
		firstLed = ledOut[0];
		waited = 0;
		while (ledOut[0] == firstLed && waited < 32)
		begin
			waitCycles(1);
			waited++;
		end
		checkCount++;
		blinkSeen: assert (ledOut[0] != firstLed)
		else
		begin
			$display("LED 0 did not toggle within 32 cycles under forced error");
			errorCount++;
		end

		// Dimmed LED 1 with its link up
		linkUp = 4'b0010;
		writeReg(6, 32'h20);
		shadow[6] = 32'h20;
		waitCycles(2);
		litCount = 0;
		repeat (64)
		begin
			if (ledOut[1])
				litCount++;
			waitCycles(1);
		end
		checkValue("dim lit cycles", 32'd8, litCount);

		// Back-to-back reads come back in command order
		burstIdx = '{3, 0, 9, 6};
		foreach (burstIdx[k])
			sendReadHeader(burstIdx[k]);
		foreach (burstIdx[k])
		begin
			awaitReply($sformatf("burst read %0d", k), data);
			checkValue($sformatf("burst read %0d", k), expectedRead(burstIdx[k]), data);
		end

		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog in case a command never completes
	initial
	begin
		#100000;
		$display("run exceeded its time limit");
		$display("sim failed");
		$finish;
	end

endmodule

//--- build.f
design/fpgaRegPkg.sv
design/cmdFifo.sv
design/cmdFrontEnd.sv
design/regSequencer.sv
design/regBank.sv
design/ledDriver.sv
design/regAccessTop.sv
testbench/regAccessTb.sv

//--- Makefile
# Verilator build and run for the register access subsystem

VERILATOR ?= verilator
TOP ?= regAccessTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= sim passed

SOURCES := $(wildcard design/*.sv) $(wildcard testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
